// File: common/tempSensPkg.sv
`default_nettype none

package tempSensPkg;

    // Parent phases of the measurement loop
    typedef enum logic [2:0] {
        PRECHARGE,
        BANDGAP,
        PTAT,
        TEMPSENS,
        SLEEP
    } phase_t;

    // One diode sampling round
    typedef enum logic [1:0] {
        SMALLDIODE,
        SMALLBLANK,
        BIGDIODE,
        BIGBLANK
    } sampleStep_t;

    typedef logic [7:0] tempCount_t;
    typedef logic [7:0] phaseCount_t;
    typedef logic [4:0] stepCount_t;
    typedef logic [2:0] roundCount_t;
    typedef logic [1:0] credit_t;

    // Phase lengths in clock cycles
    localparam phaseCount_t prechargeCycles = 8'd16;
    localparam phaseCount_t senseCycles = 8'd201;
    localparam phaseCount_t sleepCycles = 8'd31;

    // Sampler step lengths and round counts
    localparam stepCount_t bandgapStep = 5'd8;
    localparam stepCount_t ptatStep = 5'd16;
    localparam roundCount_t bandgapRounds = 3'd4;
    localparam roundCount_t ptatRounds = 3'd4;

    // Edges seen this soon after a counted one are chop glitches
    localparam logic [1:0] blankCycles = 2'd2;

    localparam credit_t creditInit = 2'd2;

endpackage

`default_nettype wire

// File: sequencer/diodeSampler.sv
`default_nettype none

module diodeSampler (
    input wire clk,
    input wire reset,
    input wire sampleEnable,
    input wire tempSensPkg::stepCount_t stepCycles,

    output logic pi1,
    output logic pi2,
    output logic pii1,
    output logic pii2,
    output logic roundDone,
    output logic sampleChop
);

    tempSensPkg::sampleStep_t step;
    tempSensPkg::stepCount_t stepCount;

    logic stepLast;
    logic bigOn;
    logic smallOn;

    assign stepLast = (stepCount == stepCycles - 5'd1);
    assign roundDone = sampleEnable && (step == tempSensPkg::BIGBLANK);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step <= tempSensPkg::SMALLDIODE;
            stepCount <= '0;
            sampleChop <= 1'b0;
        end else if (!sampleEnable) begin
            // Next enable starts a new round
            step <= tempSensPkg::SMALLDIODE;
            stepCount <= '0;
        end else begin
            case (step)
                tempSensPkg::SMALLDIODE: begin
                    stepCount <= stepLast ? '0 : stepCount + 5'd1;
                    if (stepLast) begin
                        step <= tempSensPkg::SMALLBLANK;
                        sampleChop <= ~sampleChop;
                    end
                end
                tempSensPkg::SMALLBLANK: begin
                    step <= tempSensPkg::BIGDIODE;
                end
                tempSensPkg::BIGDIODE: begin
                    stepCount <= stepLast ? '0 : stepCount + 5'd1;
                    if (stepLast) begin
                        step <= tempSensPkg::BIGBLANK;
                    end
                end
                default: begin
                    step <= tempSensPkg::SMALLDIODE;
                end
            endcase
        end
    end

    // Diode switches registered, both phases of a pair together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bigOn <= 1'b0;
            smallOn <= 1'b0;
        end else begin
            bigOn <= sampleEnable && (step == tempSensPkg::BIGDIODE);
            smallOn <= sampleEnable && (step == tempSensPkg::SMALLDIODE);
        end
    end

    assign pi1 = bigOn;
    assign pi2 = bigOn;
    assign pii1 = smallOn;
    assign pii2 = smallOn;

endmodule

`default_nettype wire

// File: sequencer/phaseSequencer.sv
`default_nettype none

module phaseSequencer (
    input wire clk,
    input wire reset,
    input wire senseChop,
    input wire resultBusy,

    output logic countEnable,
    output logic countClear,
    output logic resultPush,

    output logic cmpP1,
    output logic cmpP2,

    output logic pi1,
    output logic pi2,
    output logic pii1,
    output logic pii2,

    output logic sBgCtrl,
    output logic sPtatCtrl,
    output logic sBg2Cmp,
    output logic sCap2Cmp,
    output logic sRef2Cmp,
    output logic sCapRst,
    output logic sPtatOut,
    output logic sRdisconN,

    output logic preChrg,
    output logic pwrUp
);

    tempSensPkg::phase_t phase;
    tempSensPkg::phaseCount_t phaseCount;
    tempSensPkg::roundCount_t roundCount;
    tempSensPkg::stepCount_t stepCycles;

    logic sampleEnable;
    logic roundDone;
    logic sampleChop;
    logic chopFromSense;
    logic prechargeDone;
    logic senseDone;
    logic sleepDone;
    logic bandgapDone;
    logic ptatDone;

    assign sampleEnable = (phase == tempSensPkg::BANDGAP) || (phase == tempSensPkg::PTAT);
    assign stepCycles = (phase == tempSensPkg::PTAT) ? tempSensPkg::ptatStep
                                                     : tempSensPkg::bandgapStep;

    diodeSampler diodeSampler_inst (
        .clk(clk),
        .reset(reset),
        .sampleEnable(sampleEnable),
        .stepCycles(stepCycles),
        .pi1(pi1),
        .pi2(pi2),
        .pii1(pii1),
        .pii2(pii2),
        .roundDone(roundDone),
        .sampleChop(sampleChop)
    );

    assign prechargeDone = (phaseCount == tempSensPkg::prechargeCycles - 8'd1);
    assign senseDone = (phaseCount == tempSensPkg::senseCycles - 8'd1);
    assign sleepDone = (phaseCount == tempSensPkg::sleepCycles - 8'd1);
    assign bandgapDone = roundDone && (roundCount == tempSensPkg::bandgapRounds - 3'd1);
    assign ptatDone = roundDone && (roundCount == tempSensPkg::ptatRounds - 3'd1);

    assign countEnable = (phase == tempSensPkg::TEMPSENS);
    // Fresh count for the window about to start
    assign countClear = (phase == tempSensPkg::PTAT) && ptatDone;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= tempSensPkg::PRECHARGE;
            phaseCount <= '0;
            roundCount <= '0;
        end else begin
            case (phase)
                tempSensPkg::PRECHARGE: begin
                    phaseCount <= prechargeDone ? '0 : phaseCount + 8'd1;
                    if (prechargeDone) begin
                        phase <= tempSensPkg::BANDGAP;
                    end
                end
                tempSensPkg::BANDGAP: begin
                    if (bandgapDone) begin
                        roundCount <= '0;
                        phase <= tempSensPkg::PTAT;
                    end else if (roundDone) begin
                        roundCount <= roundCount + 3'd1;
                    end
                end
                tempSensPkg::PTAT: begin
                    if (ptatDone) begin
                        roundCount <= '0;
                        phase <= tempSensPkg::TEMPSENS;
                    end else if (roundDone) begin
                        roundCount <= roundCount + 3'd1;
                    end
                end
                tempSensPkg::TEMPSENS: begin
                    phaseCount <= senseDone ? '0 : phaseCount + 8'd1;
                    if (senseDone) begin
                        phase <= tempSensPkg::SLEEP;
                    end
                end
                default: begin
                    // Sleep holds until the last result has left
                    if (!sleepDone) begin
                        phaseCount <= phaseCount + 8'd1;
                    end else if (!resultBusy) begin
                        phaseCount <= '0;
                        phase <= tempSensPkg::BANDGAP;
                    end
                end
            endcase
        end
    end

    // Switch controls follow the phase one cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {sBgCtrl, sPtatCtrl, sBg2Cmp, sCap2Cmp, sRef2Cmp} <= '0;
            {sCapRst, sPtatOut, sRdisconN, preChrg, pwrUp} <= '0;
            resultPush <= 1'b0;
            chopFromSense <= 1'b1;
        end else begin
            sBgCtrl <= (phase == tempSensPkg::PRECHARGE) || (phase == tempSensPkg::BANDGAP);
            sPtatCtrl <= (phase == tempSensPkg::PRECHARGE) || (phase == tempSensPkg::PTAT)
                         || (phase == tempSensPkg::TEMPSENS);
            sBg2Cmp <= sampleEnable;
            sCap2Cmp <= countEnable;
            sRef2Cmp <= countEnable;
            sPtatOut <= countEnable;
            sCapRst <= (phase == tempSensPkg::PRECHARGE) || (phase == tempSensPkg::SLEEP);
            sRdisconN <= (phase == tempSensPkg::PRECHARGE) || (phase == tempSensPkg::BANDGAP)
                         || (phase == tempSensPkg::SLEEP);
            preChrg <= (phase == tempSensPkg::PRECHARGE);
            pwrUp <= (phase != tempSensPkg::SLEEP);
            resultPush <= countEnable && senseDone;
            chopFromSense <= countEnable;
        end
    end

    // Sense chop owns the comparator inside the window
    assign cmpP1 = chopFromSense ? senseChop : sampleChop;
    assign cmpP2 = ~cmpP1;

endmodule

`default_nettype wire

// File: design/cmpFrontEnd.sv
`default_nettype none

module cmpFrontEnd (
    input wire clk,
    input wire reset,
    input wire cmp,
    input wire countEnable,
    input wire countClear,

    output tempSensPkg::tempCount_t edgeCount,
    output logic senseChop
);

    logic cmpMeta;
    logic cmpSync;
    logic cmpPrev;
    logic cmpRise;
    logic edgeTaken;
    logic [1:0] blankCount;

    // Two-flop synchronizer, then edge-detect register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmpMeta <= 1'b0;
            cmpSync <= 1'b0;
            cmpPrev <= 1'b0;
        end else begin
            cmpMeta <= cmp;
            cmpSync <= cmpMeta;
            cmpPrev <= cmpSync;
        end
    end

    assign cmpRise = cmpSync & ~cmpPrev;

    // Counted only inside the window and outside blanking
    assign edgeTaken = cmpRise && countEnable && (blankCount == 2'd0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            edgeCount <= '0;
            blankCount <= 2'd0;
            senseChop <= 1'b1;
        end else if (countClear) begin
            edgeCount <= '0;
            blankCount <= 2'd0;
        end else if (edgeTaken) begin
            edgeCount <= edgeCount + tempSensPkg::tempCount_t'(1);
            blankCount <= tempSensPkg::blankCycles;
            // Each counted edge flips the comparator chop
            senseChop <= ~senseChop;
        end else if (blankCount != 2'd0) begin
            blankCount <= blankCount - 2'd1;
        end
    end

endmodule

`default_nettype wire

// File: design/resultSender.sv
`default_nettype none

module resultSender (
    input wire clk,
    input wire reset,
    input wire resultPush,
    input wire tempSensPkg::tempCount_t edgeCount,
    input wire resultCredit,

    output logic resultBusy,
    output logic resultValid,
    output tempSensPkg::tempCount_t resultData
);

    tempSensPkg::credit_t credits;

    logic creditAvail;
    logic sendNow;

    // A credit arriving this cycle can be spent right away
    assign creditAvail = (credits != 2'd0) || resultCredit;
    assign sendNow = (resultPush || resultBusy) && creditAvail;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= tempSensPkg::creditInit;
            resultBusy <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            credits <= credits + {1'b0, resultCredit} - {1'b0, sendNow};
            resultValid <= sendNow;
            if (sendNow) begin
                resultBusy <= 1'b0;
            end else if (resultPush) begin
                resultBusy <= 1'b1;
            end
        end
    end

    // Result held until it goes out
    always_ff @(posedge clk) begin
        if (resultPush) begin
            resultData <= edgeCount;
        end
    end

endmodule

`default_nettype wire

// File: design/tempSensTop.sv
`default_nettype none

module tempSensTop (
    input wire clk,
    input wire reset,
    input wire cmp,
    input wire resultCredit,

    output logic cmpP1,
    output logic cmpP2,

    output logic pi1,
    output logic pi2,
    output logic pii1,
    output logic pii2,

    output logic sBgCtrl,
    output logic sPtatCtrl,
    output logic sBg2Cmp,
    output logic sCap2Cmp,
    output logic sRef2Cmp,
    output logic sCapRst,
    output logic sPtatOut,
    output logic sRdisconN,

    output logic preChrg,
    output logic pwrUp,

    output logic resultValid,
    output tempSensPkg::tempCount_t resultData
);

    logic countEnable;
    logic countClear;
    logic senseChop;
    logic resultPush;
    logic resultBusy;
    tempSensPkg::tempCount_t edgeCount;

    // Comparator side
    cmpFrontEnd cmpFrontEnd_inst (
        .clk(clk),
        .reset(reset),
        .cmp(cmp),
        .countEnable(countEnable),
        .countClear(countClear),
        .edgeCount(edgeCount),
        .senseChop(senseChop)
    );

    phaseSequencer phaseSequencer_inst (
        .clk(clk),
        .reset(reset),
        .senseChop(senseChop),
        .resultBusy(resultBusy),
        .countEnable(countEnable),
        .countClear(countClear),
        .resultPush(resultPush),
        .cmpP1(cmpP1),
        .cmpP2(cmpP2),
        .pi1(pi1),
        .pi2(pi2),
        .pii1(pii1),
        .pii2(pii2),
        .sBgCtrl(sBgCtrl),
        .sPtatCtrl(sPtatCtrl),
        .sBg2Cmp(sBg2Cmp),
        .sCap2Cmp(sCap2Cmp),
        .sRef2Cmp(sRef2Cmp),
        .sCapRst(sCapRst),
        .sPtatOut(sPtatOut),
        .sRdisconN(sRdisconN),
        .preChrg(preChrg),
        .pwrUp(pwrUp)
    );

    // Result goes out against consumer credits
    resultSender resultSender_inst (
        .clk(clk),
        .reset(reset),
        .resultPush(resultPush),
        .edgeCount(edgeCount),
        .resultCredit(resultCredit),
        .resultBusy(resultBusy),
        .resultValid(resultValid),
        .resultData(resultData)
    );

endmodule

`default_nettype wire

// File: tb/tempSensModel.svh
`ifndef TEMP_SENS_MODEL_SVH
`define TEMP_SENS_MODEL_SVH

// Phase and step lengths as plain integers
localparam int preLen = int'(tempSensPkg::prechargeCycles);
localparam int senseLen = int'(tempSensPkg::senseCycles);
localparam int sleepLen = int'(tempSensPkg::sleepCycles);
localparam int bgStep = int'(tempSensPkg::bandgapStep);
localparam int ptStep = int'(tempSensPkg::ptatStep);
localparam int bgRounds = int'(tempSensPkg::bandgapRounds);
localparam int ptRounds = int'(tempSensPkg::ptatRounds);
localparam int blankLen = int'(tempSensPkg::blankCycles);

tempSensPkg::phase_t mPhase;
tempSensPkg::phase_t mOutPhase;
int mPhaseCyc;
logic mOutValid;
logic mPrevSmall;
logic mPrevBig;
logic mSampleChop;
logic mMeta;
logic mSync;
logic mPrev;
int mBlank;
tempSensPkg::tempCount_t mCount;
logic mSenseChop;
logic mPush;
logic mBusy;
logic mValid;
int mCredits;
int mStall;
tempSensPkg::tempCount_t expectQ[$];

// {sBgCtrl, sPtatCtrl, sBg2Cmp, sCap2Cmp, sRef2Cmp, sCapRst, sPtatOut, sRdisconN, preChrg, pwrUp}
function automatic logic [9:0] switchSet(input tempSensPkg::phase_t p);
    case (p)
        tempSensPkg::PRECHARGE: switchSet = 10'b11000101_11;
        tempSensPkg::BANDGAP: switchSet = 10'b10100001_01;
        tempSensPkg::PTAT: switchSet = 10'b01100000_01;
        tempSensPkg::TEMPSENS: switchSet = 10'b01011010_01;
        default: switchSet = 10'b00000101_00;
    endcase
endfunction

task automatic resetModel();
    mPhase = tempSensPkg::PRECHARGE;
    mOutPhase = tempSensPkg::PRECHARGE;
    mPhaseCyc = 0;
    mOutValid = 1'b0;
    mPrevSmall = 1'b0;
    mPrevBig = 1'b0;
    mSampleChop = 1'b0;
    mMeta = 1'b0;
    mSync = 1'b0;
    mPrev = 1'b0;
    mBlank = 0;
    mCount = '0;
    mSenseChop = 1'b1;
    mPush = 1'b0;
    mBusy = 1'b0;
    mValid = 1'b0;
    mCredits = int'(tempSensPkg::creditInit);
    mStall = 0;
endtask

// One clock edge, using the inputs the DUT sees at that edge
task automatic advanceModel(input logic cmpIn, input logic creditIn);
    tempSensPkg::phase_t nextPhase;
    int stepLen;
    int pos;
    logic sampling;
    logic take;
    logic send;
    logic lastSense;

    sampling = (mPhase == tempSensPkg::BANDGAP) || (mPhase == tempSensPkg::PTAT);
    stepLen = (mPhase == tempSensPkg::PTAT) ? ptStep : bgStep;
    pos = mPhaseCyc % (2 * stepLen + 2);
    take = mSync && !mPrev && (mPhase == tempSensPkg::TEMPSENS) && (mBlank == 0);
    send = (mPush || mBusy) && ((mCredits > 0) || creditIn);
    lastSense = (mPhase == tempSensPkg::TEMPSENS) && (mPhaseCyc == senseLen - 1);

    nextPhase = mPhase;
    case (mPhase)
        tempSensPkg::PRECHARGE: begin
            if (mPhaseCyc == preLen - 1) begin
                nextPhase = tempSensPkg::BANDGAP;
            end
        end
        tempSensPkg::BANDGAP: begin
            if (mPhaseCyc == bgRounds * (2 * bgStep + 2) - 1) begin
                nextPhase = tempSensPkg::PTAT;
            end
        end
        tempSensPkg::PTAT: begin
            if (mPhaseCyc == ptRounds * (2 * ptStep + 2) - 1) begin
                nextPhase = tempSensPkg::TEMPSENS;
            end
        end
        tempSensPkg::TEMPSENS: begin
            if (lastSense) begin
                nextPhase = tempSensPkg::SLEEP;
            end
        end
        default: begin
            // Sleep stretched while a result waits for a credit
            if (mPhaseCyc >= sleepLen - 1) begin
                if (mBusy) begin
                    mStall++;
                end else begin
                    nextPhase = tempSensPkg::BANDGAP;
                end
            end
        end
    endcase

    // Diode switches show this cycle's step one cycle later
    mPrevSmall = sampling && (pos < stepLen);
    mPrevBig = sampling && (pos > stepLen) && (pos <= 2 * stepLen);
    if (sampling && (pos == stepLen - 1)) begin
        mSampleChop = !mSampleChop;
    end

    if ((nextPhase == tempSensPkg::TEMPSENS) && (mPhase != tempSensPkg::TEMPSENS)) begin
        mCount = '0;
        mBlank = 0;
    end else if (take) begin
        mCount = mCount + 8'd1;
        mBlank = blankLen;
        mSenseChop = !mSenseChop;
    end else if (mBlank > 0) begin
        mBlank--;
    end
    if (lastSense) begin
        expectQ.push_back(mCount);
    end
    mPrev = mSync;
    mSync = mMeta;
    mMeta = cmpIn;

    mCredits = mCredits + (creditIn ? 1 : 0) - (send ? 1 : 0);
    mBusy = !send && (mBusy || mPush);
    mValid = send;
    mPush = lastSense;

    mOutPhase = mPhase;
    mOutValid = 1'b1;
    mPhaseCyc = (nextPhase != mPhase) ? 0 : mPhaseCyc + 1;
    mPhase = nextPhase;
endtask

`endif

// File: tb/tempSensTb.sv
`default_nettype none

module tempSensTb;

    localparam int resultsWanted = 6;
    localparam int maxCycles = 20000;
    // Extra hold on two credits so that sleep has to wait
    localparam int holdDelay = 1000;

    logic clk;
    logic reset;
    logic cmp;
    logic resultCredit;
    logic cmpP1;
    logic cmpP2;
    logic pi1;
    logic pi2;
    logic pii1;
    logic pii2;
    logic sBgCtrl;
    logic sPtatCtrl;
    logic sBg2Cmp;
    logic sCap2Cmp;
    logic sRef2Cmp;
    logic sCapRst;
    logic sPtatOut;
    logic sRdisconN;
    logic preChrg;
    logic pwrUp;
    logic resultValid;
    tempSensPkg::tempCount_t resultData;

    int seed;
    int cycleNum;
    int cmpGap;
    int validsSeen;
    int creditsBack;
    int creditDue[$];

    `include "tempSensModel.svh"

    tempSensTop tempSensTop_inst (
        .clk(clk),
        .reset(reset),
        .cmp(cmp),
        .resultCredit(resultCredit),
        .cmpP1(cmpP1),
        .cmpP2(cmpP2),
        .pi1(pi1),
        .pi2(pi2),
        .pii1(pii1),
        .pii2(pii2),
        .sBgCtrl(sBgCtrl),
        .sPtatCtrl(sPtatCtrl),
        .sBg2Cmp(sBg2Cmp),
        .sCap2Cmp(sCap2Cmp),
        .sRef2Cmp(sRef2Cmp),
        .sCapRst(sCapRst),
        .sPtatOut(sPtatOut),
        .sRdisconN(sRdisconN),
        .preChrg(preChrg),
        .pwrUp(pwrUp),
        .resultValid(resultValid),
        .resultData(resultData)
    );

    always #5 clk = ~clk;

    function automatic int pickBelow(input int span);
        int r;
        r = $random(seed);
        pickBelow = (r & 32'h7fffffff) % span;
    endfunction

    task automatic stopRun();
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkSwitches(input logic [9:0] got, input logic [9:0] exp);
        if (got !== exp) begin
            $display("error at %0t: switch controls are %b, expected %b", $time, got, exp);
            stopRun();
        end
    endtask

    task automatic checkResult(input tempSensPkg::tempCount_t got,
                               input tempSensPkg::tempCount_t exp);
        if (got !== exp) begin
            $display("error at %0t: resultData is %0d, expected %0d", $time, got, exp);
            stopRun();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkOutputs();
        logic [9:0] gotSw;
        logic expP1;
        gotSw = {sBgCtrl, sPtatCtrl, sBg2Cmp, sCap2Cmp, sRef2Cmp,
                 sCapRst, sPtatOut, sRdisconN, preChrg, pwrUp};
        checkSwitches(gotSw, mOutValid ? switchSet(mOutPhase) : 10'd0);
        if ((pi1 | pi2) & (pii1 | pii2)) begin
            $display("Big and small diode switches were on together at %0t", $time);
            stopRun();
        end
        checkBit("pii1", pii1, mPrevSmall);
        checkBit("pii2", pii2, mPrevSmall);
        checkBit("pi1", pi1, mPrevBig);
        checkBit("pi2", pi2, mPrevBig);
        expP1 = (!mOutValid || (mOutPhase == tempSensPkg::TEMPSENS)) ? mSenseChop : mSampleChop;
        checkBit("cmpP1", cmpP1, expP1);
        checkBit("cmpP2", cmpP2, !expP1);
        // A credit driven this cycle has not reached the DUT yet
        if (resultValid && (validsSeen - creditsBack + int'(resultCredit)
                            >= int'(tempSensPkg::creditInit))) begin
            $display("A result was sent at %0t without a credit left", $time);
            stopRun();
        end
        checkBit("resultValid", resultValid, mValid);
        if (mValid) begin
            checkResult(resultData, expectQ.pop_front());
            if ((validsSeen == 1) || (validsSeen == 2)) begin
                creditDue.push_back(cycleNum + holdDelay + pickBelow(301));
            end else begin
                creditDue.push_back(cycleNum + pickBelow(301));
            end
            validsSeen++;
        end
    endtask

    task automatic driveInputs();
        int idx;
        int pick;
        pick = -1;
        resultCredit = 1'b0;
        for (idx = 0; idx < creditDue.size(); idx++) begin
            if ((pick < 0) && (creditDue[idx] <= cycleNum)) begin
                pick = idx;
            end
        end
        // One credit per cycle at most
        if (pick >= 0) begin
            creditDue.delete(pick);
            resultCredit = 1'b1;
            creditsBack++;
        end
        if (cmpGap == 0) begin
            cmp = !cmp;
            cmpGap = pickBelow(6);
        end else begin
            cmpGap--;
        end
    endtask

    initial begin
        int i;
        clk = 1'b0;
        reset = 1'b1;
        cmp = 1'b0;
        resultCredit = 1'b0;
        seed = 32'hbc1bd1c9;
        cycleNum = 0;
        cmpGap = 0;
        validsSeen = 0;
        creditsBack = 0;
        resetModel();

        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            checkOutputs();
        end
        reset = 1'b0;

        while (validsSeen < resultsWanted) begin
            if (cycleNum >= maxCycles) begin
                $display("Timed out waiting for results from the DUT");
                stopRun();
            end
            @(negedge clk);
            checkOutputs();
            advanceModel(cmp, resultCredit);
            @(posedge clk);
            cycleNum++;
            #1;
            driveInputs();
        end

        if (mStall == 0) begin
            $display("Sleep was never held by an unsent result");
            stopRun();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+tb
common/tempSensPkg.sv
sequencer/diodeSampler.sv
sequencer/phaseSequencer.sv
design/cmpFrontEnd.sv
design/resultSender.sv
design/tempSensTop.sv
tb/tempSensTb.sv

// File: run.sh
#!/bin/sh
# Build and run the temperature sensor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tempSensTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VtempSensTb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "FAIL"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if ! grep -q "Finished with no errors" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

echo "PASS"
exit 0
